// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = path_count_tb
FILELIST = compile.f
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run the simulation"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+include
verilog/graph_pkg.sv
verilog/graph_regs.sv
verilog/graph_store.sv
verilog/path_counter.sv
verilog/path_count_top.sv
sim/path_count_chk.sv
sim/path_count_tb.sv

// File: include/graph_regs.svh
`ifndef GRAPH_REGS_SVH
`define GRAPH_REGS_SVH

// byte offsets of the register map
`define REG_CTRL      8'h00
`define REG_EDGE      8'h04
`define REG_ENDPOINTS 8'h08
`define REG_STATUS    8'h0C
`define REG_RESULT    8'h10
`define REG_PASSES    8'h14

// bits of REG_CTRL
`define CTRL_START_BIT 0
`define CTRL_CLEAR_BIT 1

`endif

// File: sim/path_count_chk.sv
`default_nettype none

module path_count_chk (
    input wire clk,
    input wire rst_n,
    input wire cyc,
    input wire stb,
    input wire ack,
    input wire busy,
    input wire done,
    input wire edge_valid
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else $error("ack held for more than one cycle");

    ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(cyc && stb))
        else $error("ack without a cyc and stb request");

    busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
        else $error("busy and done high together");

    no_edge_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        edge_valid |-> !busy)
        else $error("edge strobe issued while the counter is busy");

endmodule

bind graph_regs path_count_chk path_count_chk_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc        (cyc),
    .stb        (stb),
    .ack        (ack),
    .busy       (busy),
    .done       (done),
    .edge_valid (edge_valid)
);

`default_nettype wire

// File: sim/path_count_tb.sv
`default_nettype none

module path_count_tb;

    import graph_pkg::*;
    `include "graph_regs.svh"

    localparam int PATH_BITS = 8;
    localparam int MAX_EDGES = 256;
    localparam int MAX_PASSES = 64;

    logic        clk;
    logic        rst_n;
    logic        cyc, stb, we;
    logic [7:0]  adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    wire         ack;
    wire [31:0]  dat_r;

    logic [31:0] rng_state = 32'd71913;
    int          checks = 0;
    int          errors = 0;
    int          test_errs = 0;
    int          n_nodes;
    int          ne;
    device_t     code [64];
    int          es [320];
    int          ed [320];

    path_count_top #(
        .MAX_EDGES  (MAX_EDGES),
        .PATH_BITS  (PATH_BITS),
        .MAX_PASSES (MAX_PASSES)
    ) path_count_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .ack   (ack),
        .dat_r (dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    function automatic int rand_below(input int k);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'((rng_state >> 8) % k);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $finish;
    endtask

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_count(input string name, input logic [PATH_BITS-1:0] got,
                               input logic [PATH_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            note_error();
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            note_error();
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_device(input string name, input device_t got, input device_t exp);
        checks++;
        if (got !== exp) begin
            note_error();
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_passes(input string name, input pass_count_t got,
                                input pass_count_t exp);
        checks++;
        if (got !== exp) begin
            note_error();
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s (%0d errors)", name, test_errs == 0 ? "ok" : "bad", test_errs);
        test_errs = 0;
    endtask

    task automatic wb_write(input logic [7:0] a, input logic [31:0] d);
        int t;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        adr <= a;
        dat_w <= d;
        sel <= 4'hF;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!ack && t < 50);
        if (!ack) abort_run("Wishbone write got no ack");
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic wb_read(input logic [7:0] a, output logic [31:0] d);
        int t;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b0;
        adr <= a;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!ack && t < 50);
        if (!ack) abort_run("Wishbone read got no ack");
        d = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic add_edge(input int s, input int d);
        es[ne] = s;
        ed[ne] = d;
        ne++;
    endtask

    // increasing codes, edges only go to higher nodes
    task automatic gen_dag(input int n);
        int k;
        n_nodes = n;
        ne = 0;
        code[0] = device_t'(1 + rand_below(40));
        for (int i = 1; i < n; i++) code[i] = code[i-1] + device_t'(1 + rand_below(50));
        for (int s = 0; s < n - 1; s++) begin
            k = rand_below(4);
            for (int j = 0; j < k; j++) add_edge(s, s + 1 + rand_below(n - 1 - s));
        end
    endtask

    task automatic send_graph();
        wb_word_u w;
        wb_write(`REG_CTRL, 32'h2); // clear
        for (int i = 0; i < ne; i++) begin
            w = '0;
            w.edge_entry.last = (i == ne - 1) || (es[i+1] != es[i]);
            w.edge_entry.device = code[es[i]];
            w.edge_entry.next_device = code[ed[i]];
            wb_write(`REG_EDGE, w);
        end
    endtask

    // jacobi passes over the edge list, start pinned at 1
    task automatic run_model(input int s, input device_t end_dev,
                             output logic [PATH_BITS-1:0] res, output int p, output logic nc);
        logic [PATH_BITS-1:0] cur [64];
        logic [PATH_BITS-1:0] nxt [64];
        logic changed;
        int end_node;
        for (int i = 0; i < n_nodes; i++) cur[i] = '0;
        cur[s] = 1;
        p = 0;
        end_node = (code[s] == end_dev) ? s : -1;
        for (int e = 0; e < ne; e++) begin
            if (code[es[e]] == end_dev) end_node = es[e];
            if (code[ed[e]] == end_dev) end_node = ed[e];
        end
        do begin
            for (int i = 0; i < n_nodes; i++) nxt[i] = (i == s) ? 1 : 0;
            for (int e = 0; e < ne; e++)
                if (ed[e] != s) nxt[ed[e]] = nxt[ed[e]] + cur[es[e]];
            changed = 1'b0;
            for (int i = 0; i < n_nodes; i++) if (nxt[i] != cur[i]) changed = 1'b1;
            cur = nxt;
            p++;
        end while (changed && p < MAX_PASSES);
        nc = changed;
        res = (end_node >= 0) ? cur[end_node] : '0;
    endtask

    task automatic set_endpoints(input device_t s_dev, input device_t e_dev);
        wb_word_u w;
        w = '0;
        w.endpoints.start_device = s_dev;
        w.endpoints.end_device = e_dev;
        wb_write(`REG_ENDPOINTS, w);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int t;
        t = 0;
        do begin
            wb_read(`REG_STATUS, st);
            t++;
        end while (!st[STAT_DONE] && t < 20000);
        if (!st[STAT_DONE]) abort_run("path count never finished");
    endtask

    task automatic count_and_check(input string name, input int s, input device_t e_dev,
                                   output logic [31:0] st, output pass_count_t got_p,
                                   output int exp_p, output logic exp_nc);
        logic [31:0] rd;
        logic [PATH_BITS-1:0] exp_res;
        set_endpoints(code[s], e_dev);
        wb_write(`REG_CTRL, 32'h1);
        wait_done();
        run_model(s, e_dev, exp_res, exp_p, exp_nc);
        wb_read(`REG_RESULT, rd);
        check_count({name, " result"}, rd[PATH_BITS-1:0], exp_res);
        wb_read(`REG_PASSES, rd);
        got_p = rd[PASS_BITS-1:0];
        wb_read(`REG_STATUS, st);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] st;
        pass_count_t pc;
        int mp;
        logic mnc;
        wb_word_u w;
        int s;
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        sel = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        wb_read(`REG_STATUS, rd);
        check_status("status after reset", rd, 32'h0);
        set_endpoints(15'h1234, 15'h4321);
        wb_read(`REG_ENDPOINTS, rd);
        w = rd;
        check_device("start_device", w.endpoints.start_device, 15'h1234);
        check_device("end_device", w.endpoints.end_device, 15'h4321);
        end_test("reset and endpoints");

        for (int r = 0; r < 4; r++) begin
            gen_dag(12);
            send_graph();
            s = rand_below(6);
            count_and_check("random dag", s, code[s + 1 + rand_below(11 - s)], st, pc, mp, mnc);
            check_status("random dag status", st, 32'h2);
            checks++;
            if (int'(pc) > mp + 1) begin
                note_error();
                $display("Fail random dag passes: got 0x%h limit 0x%h", pc, mp + 1);
            end
        end
        end_test("random dag");

        n_nodes = 20;
        ne = 0;
        for (int i = 0; i < 20; i++) code[i] = device_t'(100 + i * 7);
        for (int j = 1; j <= 3; j++) add_edge(0, j);
        for (int l = 0; l < 5; l++)
            for (int a = 0; a < 3; a++)
                for (int b = 0; b < 3; b++) add_edge(1 + 3 * l + a, 4 + 3 * l + b);
        for (int a = 16; a < 19; a++) add_edge(a, 19);
        send_graph();
        count_and_check("layered", 0, code[19], st, pc, mp, mnc);
        check_status("layered status", st, 32'h2);
        end_test("layered wrap");

        n_nodes = 3;
        ne = 0;
        code[0] = 15'h0421;
        code[1] = 15'h0842;
        code[2] = 15'h0C63;
        add_edge(0, 1);
        add_edge(1, 2);
        add_edge(2, 1);
        send_graph();
        count_and_check("cycle", 0, code[2], st, pc, mp, mnc);
        check_status("cycle status", st, 32'h6);
        check_passes("cycle passes", pc, pass_count_t'(MAX_PASSES));
        end_test("cycle");

        n_nodes = 21;
        ne = 0;
        for (int i = 0; i < 21; i++) code[i] = device_t'(1 + i * 3);
        for (int e = 0; e < 260; e++) add_edge(e / 20, 13 + e % 8);
        send_graph();
        wb_read(`REG_STATUS, rd);
        check_status("overflow set", rd & 32'h8, 32'h8);
        wb_write(`REG_CTRL, 32'h2);
        wb_read(`REG_STATUS, rd);
        check_status("overflow cleared", rd & 32'hA, 32'h0);
        gen_dag(6);
        send_graph();
        count_and_check("after clear", 0, code[5], st, pc, mp, mnc);
        check_status("after clear status", st, mnc ? 32'h6 : 32'h2);
        end_test("overflow and clear");

        gen_dag(10);
        send_graph();
        s = rand_below(5);
        set_endpoints(code[s], 15'h7FFF);
        wb_write(`REG_CTRL, 32'h1);
        wb_read(`REG_STATUS, rd);
        check_status("busy during count", rd & 32'h1, 32'h1);
        w = '0;
        w.edge_entry.last = 1'b1;
        w.edge_entry.device = code[s];
        w.edge_entry.next_device = 15'h7FFF;
        wb_write(`REG_EDGE, w); // must be dropped
        wait_done();
        wb_read(`REG_RESULT, rd);
        check_count("absent end result", rd[PATH_BITS-1:0], '0);
        wb_write(`REG_CTRL, 32'h1);
        wait_done();
        wb_read(`REG_RESULT, rd);
        check_count("second start result", rd[PATH_BITS-1:0], '0);
        end_test("absent end and busy writes");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/graph_pkg.sv
`default_nettype none

package graph_pkg;

    // each letter of a device name is coded in 5 bits
    localparam int DEVICE_CHARS = 3;
    localparam int DEVICE_BIN_BITS = 5;
    localparam int DEVICE_WIDTH = DEVICE_CHARS * DEVICE_BIN_BITS;

    localparam int PASS_BITS = 7; // holds up to 127 passes

    typedef logic [DEVICE_WIDTH-1:0] device_t;
    typedef logic [PASS_BITS-1:0] pass_count_t;

    // write word of REG_EDGE
    typedef struct packed {
        logic    last; // final entry of this device
        logic    reserved;
        device_t device;
        device_t next_device;
    } edge_word_t;

    // write and read word of REG_ENDPOINTS
    typedef struct packed {
        logic [1:0] reserved;
        device_t    start_device;
        device_t    end_device;
    } endpoint_word_t;

    typedef union packed {
        edge_word_t     edge_entry;
        endpoint_word_t endpoints;
    } wb_word_u;

    // bit positions in REG_STATUS
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_NO_CONVERGE = 2;
    localparam int STAT_EDGE_OVERFLOW = 3;

endpackage

`default_nettype wire

// File: verilog/graph_regs.sv
`default_nettype none

module graph_regs #(
    parameter int PATH_BITS = 8
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       cyc,
    input  wire                       stb,
    input  wire                       we,
    input  wire [7:0]                 adr,
    input  wire [31:0]                dat_w,
    input  wire [3:0]                 sel,
    output logic                      ack,
    output logic [31:0]               dat_r,
    output logic                      edge_valid,
    output logic                      edge_last,
    output graph_pkg::device_t        edge_device,
    output graph_pkg::device_t        edge_next,
    output logic                      graph_clear,
    output logic                      start,
    output graph_pkg::device_t        start_device,
    output graph_pkg::device_t        end_device,
    input  wire                       busy,
    input  wire                       done,
    input  wire                       no_converge,
    input  wire                       edge_overflow,
    input  wire [PATH_BITS-1:0]       result,
    input  wire graph_pkg::pass_count_t passes
);

    import graph_pkg::*;
    `include "graph_regs.svh"

    wb_word_u    wr_word;
    wb_word_u    ep_word;
    logic        access;
    logic        wr_ok;
    logic        ctrl_wr;
    logic [31:0] status_word;
    logic [31:0] rd_mux;

    assign access = cyc && stb && !ack; // one ack per request
    assign wr_ok = access && we && (&sel); // partial writes are acked only
    assign ctrl_wr = wr_ok && adr == `REG_CTRL && !busy;
    assign wr_word = dat_w;

    always_comb begin
        ep_word = '0;
        ep_word.endpoints.start_device = start_device;
        ep_word.endpoints.end_device = end_device;
    end

    always_comb begin
        status_word = '0;
        status_word[STAT_BUSY] = busy;
        status_word[STAT_DONE] = done;
        status_word[STAT_NO_CONVERGE] = no_converge;
        status_word[STAT_EDGE_OVERFLOW] = edge_overflow;
    end

    always_comb begin
        case (adr)
            `REG_ENDPOINTS: rd_mux = ep_word;
            `REG_STATUS:    rd_mux = status_word;
            `REG_RESULT:    rd_mux = 32'(result);
            `REG_PASSES:    rd_mux = 32'(passes);
            default:        rd_mux = '0; // unmapped and write-only
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
            edge_valid <= 1'b0;
            graph_clear <= 1'b0;
            start <= 1'b0;
            start_device <= '0;
            end_device <= '0;
        end else begin
            ack <= cyc && stb && !ack;
            edge_valid <= wr_ok && adr == `REG_EDGE && !busy;
            graph_clear <= ctrl_wr && dat_w[`CTRL_CLEAR_BIT];
            // clear wins over start in the same write
            start <= ctrl_wr && dat_w[`CTRL_START_BIT] && !dat_w[`CTRL_CLEAR_BIT];
            if (wr_ok && adr == `REG_ENDPOINTS) begin
                start_device <= wr_word.endpoints.start_device;
                end_device <= wr_word.endpoints.end_device;
            end
        end
    end

    // edge payload travels with the edge_valid strobe
    always_ff @(posedge clk) begin
        edge_last <= wr_word.edge_entry.last;
        edge_device <= wr_word.edge_entry.device;
        edge_next <= wr_word.edge_entry.next_device;
        dat_r <= rd_mux;
    end

endmodule

`default_nettype wire

// File: verilog/graph_store.sv
`default_nettype none

module graph_store #(
    parameter int MAX_EDGES = 2048,
    parameter int MAX_OUTPUTS = 30,
    localparam int EDGE_AW = $clog2(MAX_EDGES),
    localparam int CNT_W = EDGE_AW + 1,
    localparam int OUT_W = $clog2(MAX_OUTPUTS + 1)
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 edge_valid,
    input  wire                 edge_last,
    input  wire graph_pkg::device_t edge_device,
    input  wire graph_pkg::device_t edge_next,
    input  wire                 graph_clear,
    input  wire [EDGE_AW-1:0]   src_index,
    input  wire [EDGE_AW-1:0]   conn_index,
    output graph_pkg::device_t  src_device,
    output logic [EDGE_AW-1:0]  src_start_ptr,
    output logic [OUT_W-1:0]    src_outputs,
    output graph_pkg::device_t  conn_device,
    output logic [CNT_W-1:0]    src_count,
    output logic [CNT_W-1:0]    edge_count,
    output logic                edge_overflow
);

    import graph_pkg::*;

    device_t                    conn_mem [MAX_EDGES]; // destination of every edge
    device_t                    src_mem [MAX_EDGES]; // devices in arrival order
    logic [EDGE_AW+OUT_W-1:0]   adj_mem [2**DEVICE_WIDTH]; // {start_ptr, outputs}

    logic [OUT_W-1:0]   out_cnt; // entries seen so far for this device
    logic [EDGE_AW-1:0] grp_ptr;
    logic               full;
    logic               store_ok;

    assign full = edge_count == CNT_W'(MAX_EDGES);
    assign store_ok = edge_valid && !full;
    assign grp_ptr = edge_count[EDGE_AW-1:0] - EDGE_AW'(out_cnt); // first entry of group

    always_ff @(posedge clk) begin
        if (store_ok) begin
            conn_mem[edge_count[EDGE_AW-1:0]] <= edge_next;
            if (edge_last) begin
                adj_mem[edge_device] <= {grp_ptr, out_cnt + 1'b1};
                src_mem[src_count[EDGE_AW-1:0]] <= edge_device;
            end
        end
    end

    // read ports, one cycle of latency
    always_ff @(posedge clk) begin
        src_device <= src_mem[src_index];
        {src_start_ptr, src_outputs} <= adj_mem[src_mem[src_index]];
        conn_device <= conn_mem[conn_index];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_count <= '0;
            src_count <= '0;
            out_cnt <= '0;
            edge_overflow <= 1'b0;
        end else if (graph_clear) begin
            edge_count <= '0;
            src_count <= '0;
            out_cnt <= '0;
            edge_overflow <= 1'b0;
        end else if (edge_valid) begin
            if (full) begin
                edge_overflow <= 1'b1; // sticky, edge is dropped
            end else begin
                edge_count <= edge_count + 1'b1;
                if (edge_last) begin
                    src_count <= src_count + 1'b1;
                    out_cnt <= '0;
                end else begin
                    out_cnt <= out_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/path_count_top.sv
`default_nettype none

module path_count_top #(
    parameter int MAX_EDGES = 2048,
    parameter int MAX_OUTPUTS = 30,
    parameter int PATH_BITS = 8,
    parameter int MAX_PASSES = 64
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         cyc,
    input  wire         stb,
    input  wire         we,
    input  wire [7:0]   adr,
    input  wire [31:0]  dat_w,
    input  wire [3:0]   sel,
    output logic        ack,
    output logic [31:0] dat_r
);

    import graph_pkg::*;

    localparam int EDGE_AW = $clog2(MAX_EDGES);
    localparam int CNT_W = EDGE_AW + 1;
    localparam int OUT_W = $clog2(MAX_OUTPUTS + 1);

    logic                 edge_valid, edge_last, graph_clear, start;
    device_t              edge_device, edge_next, start_device, end_device;
    logic                 busy, done, no_converge, edge_overflow;
    logic [PATH_BITS-1:0] result;
    pass_count_t          passes;

    logic [EDGE_AW-1:0]   src_index, conn_index, src_start_ptr;
    device_t              src_device, conn_device;
    logic [OUT_W-1:0]     src_outputs;
    logic [CNT_W-1:0]     src_count, edge_count;

    graph_regs #(
        .PATH_BITS (PATH_BITS)
    ) graph_regs_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .dat_w         (dat_w),
        .sel           (sel),
        .ack           (ack),
        .dat_r         (dat_r),
        .edge_valid    (edge_valid),
        .edge_last     (edge_last),
        .edge_device   (edge_device),
        .edge_next     (edge_next),
        .graph_clear   (graph_clear),
        .start         (start),
        .start_device  (start_device),
        .end_device    (end_device),
        .busy          (busy),
        .done          (done),
        .no_converge   (no_converge),
        .edge_overflow (edge_overflow),
        .result        (result),
        .passes        (passes)
    );

    graph_store #(
        .MAX_EDGES   (MAX_EDGES),
        .MAX_OUTPUTS (MAX_OUTPUTS)
    ) graph_store_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .edge_valid    (edge_valid),
        .edge_last     (edge_last),
        .edge_device   (edge_device),
        .edge_next     (edge_next),
        .graph_clear   (graph_clear),
        .src_index     (src_index),
        .conn_index    (conn_index),
        .src_device    (src_device),
        .src_start_ptr (src_start_ptr),
        .src_outputs   (src_outputs),
        .conn_device   (conn_device),
        .src_count     (src_count),
        .edge_count    (edge_count),
        .edge_overflow (edge_overflow)
    );

    path_counter #(
        .MAX_EDGES   (MAX_EDGES),
        .MAX_OUTPUTS (MAX_OUTPUTS),
        .PATH_BITS   (PATH_BITS),
        .MAX_PASSES  (MAX_PASSES)
    ) path_counter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .start_device  (start_device),
        .end_device    (end_device),
        .src_index     (src_index),
        .src_device    (src_device),
        .src_start_ptr (src_start_ptr),
        .src_outputs   (src_outputs),
        .conn_index    (conn_index),
        .conn_device   (conn_device),
        .src_count     (src_count),
        .edge_count    (edge_count),
        .busy          (busy),
        .done          (done),
        .no_converge   (no_converge),
        .result        (result),
        .passes        (passes)
    );

endmodule

`default_nettype wire

// File: verilog/path_counter.sv
`default_nettype none

module path_counter #(
    parameter int MAX_EDGES = 2048,
    parameter int MAX_OUTPUTS = 30,
    parameter int PATH_BITS = 8,
    parameter int MAX_PASSES = 64,
    localparam int EDGE_AW = $clog2(MAX_EDGES),
    localparam int CNT_W = EDGE_AW + 1,
    localparam int OUT_W = $clog2(MAX_OUTPUTS + 1)
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire graph_pkg::device_t start_device,
    input  wire graph_pkg::device_t end_device,
    output logic [EDGE_AW-1:0]      src_index,
    input  wire graph_pkg::device_t src_device,
    input  wire [EDGE_AW-1:0]       src_start_ptr,
    input  wire [OUT_W-1:0]         src_outputs,
    output logic [EDGE_AW-1:0]      conn_index,
    input  wire graph_pkg::device_t conn_device,
    input  wire [CNT_W-1:0]         src_count,
    input  wire [CNT_W-1:0]         edge_count,
    output logic                    busy,
    output logic                    done,
    output logic                    no_converge,
    output logic [PATH_BITS-1:0]    result,
    output graph_pkg::pass_count_t  passes
);

    import graph_pkg::*;

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_SRC = 3'd1; // source index presented
    localparam logic [2:0] ST_SRC_RD = 3'd2; // source entry valid
    localparam logic [2:0] ST_CONN = 3'd3; // connection index presented
    localparam logic [2:0] ST_DST = 3'd4; // destination valid, counts read
    localparam logic [2:0] ST_UPD = 3'd5; // counts valid, rmw or compare
    localparam logic [2:0] ST_TAIL = 3'd6;
    localparam logic [2:0] ST_RES = 3'd7;

    localparam logic [1:0] PH_INIT = 2'd0;
    localparam logic [1:0] PH_ZERO = 2'd1;
    localparam logic [1:0] PH_ACC = 2'd2;
    localparam logic [1:0] PH_CMP = 2'd3;

    logic [PATH_BITS-1:0] bank0 [2**DEVICE_WIDTH];
    logic [PATH_BITS-1:0] bank1 [2**DEVICE_WIDTH];

    logic [2:0]           state;
    logic [1:0]           phase;
    logic [CNT_W-1:0]     src_i;
    logic [CNT_W-1:0]     edge_count_q;
    logic [EDGE_AW-1:0]   src_ptr;
    logic [OUT_W-1:0]     src_outs;
    logic [OUT_W-1:0]     edge_k;
    logic [PATH_BITS-1:0] src_cnt; // current count of the source being walked
    logic [PATH_BITS-1:0] rd0, rd1, cur_rd, nxt_rd, wr_val;
    device_t              start_q, end_q, rd_addr, wr_addr;
    logic                 cur; // bank holding the current counts
    logic                 end_seen, changed;
    logic                 we_cur, we_nxt, last_edge, advance;

    assign src_index = src_i[EDGE_AW-1:0];
    assign conn_index = src_ptr + EDGE_AW'(edge_k);
    assign cur_rd = cur ? rd1 : rd0;
    assign nxt_rd = cur ? rd0 : rd1;
    assign last_edge = (edge_k + 1'b1 == src_outs) ||
                       (CNT_W'(conn_index) + 1'b1 >= edge_count);
    assign advance = (state == ST_UPD) ||
                     (state == ST_DST && (phase == PH_INIT || phase == PH_ZERO));

    always_comb begin
        case (state)
            ST_SRC_RD: rd_addr = src_device;
            ST_TAIL:   rd_addr = end_q; // result lookup after the last swap
            default:   rd_addr = conn_device;
        endcase
    end

    always_comb begin
        we_cur = 1'b0;
        we_nxt = 1'b0;
        wr_addr = conn_device;
        wr_val = '0;
        case (state)
            ST_SRC_RD: begin
                we_cur = phase == PH_INIT;
                we_nxt = phase == PH_INIT;
                wr_addr = src_device;
            end
            ST_DST: begin
                we_cur = phase == PH_INIT;
                we_nxt = phase == PH_INIT || phase == PH_ZERO;
            end
            ST_UPD: begin
                we_nxt = phase == PH_ACC && conn_device != start_q; // start stays at 1
                wr_val = nxt_rd + src_cnt; // wraps mod 2**PATH_BITS
            end
            ST_TAIL: begin
                we_cur = phase == PH_INIT;
                we_nxt = phase == PH_ZERO;
                wr_addr = start_q;
                wr_val = PATH_BITS'(1);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cur ? we_nxt : we_cur) bank0[wr_addr] <= wr_val;
        if (cur ? we_cur : we_nxt) bank1[wr_addr] <= wr_val;
        rd0 <= bank0[rd_addr];
        rd1 <= bank1[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            start_q <= start_device;
            end_q <= end_device;
        end
        if (state == ST_SRC_RD) begin
            src_ptr <= src_start_ptr;
            src_outs <= src_outputs;
        end
        if (state == ST_CONN && edge_k == '0) src_cnt <= cur_rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            phase <= PH_INIT;
            src_i <= '0;
            edge_k <= '0;
            edge_count_q <= '0;
            cur <= 1'b0;
            end_seen <= 1'b0;
            changed <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            no_converge <= 1'b0;
            result <= '0;
            passes <= '0;
        end else begin
            edge_count_q <= edge_count;
            if (edge_count < edge_count_q) done <= 1'b0; // graph was cleared
            case (state)
                ST_IDLE: if (start) begin
                    state <= ST_SRC;
                    phase <= PH_INIT;
                    src_i <= '0;
                    busy <= 1'b1;
                    done <= 1'b0;
                    no_converge <= 1'b0;
                    passes <= '0;
                    end_seen <= start_device == end_device;
                end
                ST_SRC: state <= (src_i == src_count) ? ST_TAIL : ST_SRC_RD;
                ST_SRC_RD: begin
                    edge_k <= '0;
                    state <= ST_CONN;
                    if (src_device == end_q) end_seen <= 1'b1;
                end
                ST_CONN: state <= ST_DST;
                ST_DST: begin
                    if (conn_device == end_q) end_seen <= 1'b1;
                    if (!advance) state <= ST_UPD;
                end
                ST_UPD: if (phase == PH_CMP && cur_rd != nxt_rd) changed <= 1'b1;
                ST_TAIL: begin
                    src_i <= '0;
                    state <= ST_SRC;
                    case (phase)
                        PH_INIT: phase <= PH_ZERO;
                        PH_ZERO: phase <= PH_ACC;
                        PH_ACC: begin
                            phase <= PH_CMP;
                            changed <= 1'b0;
                        end
                        default: begin
                            passes <= passes + 1'b1;
                            cur <= !cur; // next bank becomes current
                            phase <= PH_ZERO;
                            if (!changed || passes == MAX_PASSES - 1) begin
                                no_converge <= changed;
                                state <= ST_RES;
                            end
                        end
                    endcase
                end
                default: begin
                    result <= end_seen ? cur_rd : '0;
                    busy <= 1'b0;
                    done <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
            // step to the next edge or the next source
            if (advance) begin
                if (last_edge) begin
                    src_i <= src_i + 1'b1;
                    state <= ST_SRC;
                end else begin
                    edge_k <= edge_k + 1'b1;
                    state <= ST_CONN;
                end
            end
        end
    end

endmodule

`default_nettype wire
